// File: all.f
design/id_pkg.sv
design/id_decoder.sv
design/id_operand_mux.sv
design/id_controller.sv
design/id_stage_top.sv
testbench/id_controller_assertions.sv
testbench/id_stage_tb.sv

// File: design/id_controller.sv
////////////////////
// ID stage controller
// FSM, stalls, branch/jump PC set and write/request gating
////////////////////

`timescale 1ns/1ns

module id_controller import id_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic instr_valid_i,
  input  logic illegal_i,
  input  logic branch_dec_i,
  input  logic jump_dec_i,
  input  logic lsu_dec_i,
  input  logic rf_we_dec_i,
  input  logic lsu_we_i,
  input  logic branch_decision_i,
  input  logic lsu_resp_valid_i,
  output logic lsu_req_o,
  output logic rf_we_o,
  output logic pc_set_o,
  output logic instr_done_o,
  output logic illegal_insn_o
);

  id_fsm_e id_fsm_q, id_fsm_d;

  logic lsu_en, branch_en, jump_en;
  logic first_cycle;
  logic multicycle_done;
  logic stall_mem, stall_branch, stall_jump, stall_id;
  logic branch_set_d, branch_set_q;
  logic jump_set_raw;
  logic set_done_d, set_done_q;

  // Only legal, valid instructions take part
  assign lsu_en    = instr_valid_i & ~illegal_i & lsu_dec_i;
  assign branch_en = instr_valid_i & ~illegal_i & branch_dec_i;
  assign jump_en   = instr_valid_i & ~illegal_i & jump_dec_i;

  assign illegal_insn_o = instr_valid_i & illegal_i;
  assign first_cycle    = instr_valid_i & (id_fsm_q == FIRST_CYCLE);

  ////////////////////
  // ID FSM
  ////////////////////

  assign multicycle_done = lsu_en ? lsu_resp_valid_i : 1'b1;

  always_comb begin
    id_fsm_d     = id_fsm_q;
    stall_branch = 1'b0;
    stall_jump   = 1'b0;
    branch_set_d = 1'b0;
    jump_set_raw = 1'b0;

    if (instr_valid_i) begin
      case (id_fsm_q)
        FIRST_CYCLE: begin
          if (lsu_en) begin
            id_fsm_d = MULTI_CYCLE;
          end else if (branch_en) begin
            // Taken branch spends one more cycle
            id_fsm_d     = branch_decision_i ? MULTI_CYCLE : FIRST_CYCLE;
            stall_branch = branch_decision_i;
            branch_set_d = branch_decision_i;
          end else if (jump_en) begin
            id_fsm_d     = MULTI_CYCLE;
            stall_jump   = 1'b1;
            jump_set_raw = 1'b1;
          end
        end
        MULTI_CYCLE: begin
          if (multicycle_done) begin
            id_fsm_d = FIRST_CYCLE;
          end else begin
            stall_branch = branch_en;
            stall_jump   = jump_en;
          end
        end
        default: id_fsm_d = FIRST_CYCLE;
      endcase
    end
  end

  // Memory ops always stall the request cycle, then wait for the response
  assign stall_mem = lsu_en & (~lsu_resp_valid_i | first_cycle);
  assign stall_id  = stall_mem | stall_branch | stall_jump;

  assign instr_done_o = instr_valid_i & ~stall_id;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_fsm_q     <= FIRST_CYCLE;
      branch_set_q <= 1'b0;
      set_done_q   <= 1'b0;
    end else begin
      id_fsm_q     <= id_fsm_d;
      branch_set_q <= branch_set_d;
      set_done_q   <= set_done_d;
    end
  end

  ////////////////////
  // PC set and gating
  ////////////////////

  // One PC set per branch or jump, flag clears when the instruction retires
  assign set_done_d = (branch_set_q | jump_set_raw | set_done_q) & ~instr_done_o;

  assign pc_set_o = instr_valid_i & ~set_done_q & (branch_set_q | jump_set_raw);

  assign lsu_req_o = first_cycle & lsu_en;

  // No register write for stores
  assign rf_we_o = instr_done_o & ~illegal_i & rf_we_dec_i & ~(lsu_dec_i & lsu_we_i);

endmodule

// File: design/id_decoder.sv
////////////////////
// RV32I instruction decoder
// Control fields, register addresses and illegal detection
////////////////////

`timescale 1ns/1ns

module id_decoder import id_pkg::*; #(
  parameter int unsigned NumRegs = NUM_REGS_DEFAULT
) (
  input  logic [XLEN-1:0]       instr_i,
  output alu_op_e               alu_operator_o,
  output op_a_sel_e             op_a_sel_o,
  output op_b_sel_e             op_b_sel_o,
  output imm_b_sel_e            imm_b_sel_o,
  output logic [REG_ADDR_W-1:0] rf_raddr_a_o,
  output logic [REG_ADDR_W-1:0] rf_raddr_b_o,
  output logic [REG_ADDR_W-1:0] rf_waddr_o,
  output logic                  rf_we_dec_o,
  output logic                  lsu_dec_o,
  output logic                  lsu_we_o,
  output lsu_type_e             lsu_type_o,
  output logic                  lsu_sign_ext_o,
  output logic                  branch_dec_o,
  output logic                  jump_dec_o,
  output logic                  illegal_o
);

  opcode_e               opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic [REG_ADDR_W-1:0] rs1, rs2, rd;
  logic                  rs1_used, rs2_used, rd_used;
  logic                  illegal_enc, illegal_reg;
  logic                  rf_we_raw, lsu_raw, lsu_we_raw, branch_raw, jump_raw;

  assign opcode = opcode_e'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  assign rs1    = instr_i[19:15];
  assign rs2    = instr_i[24:20];
  assign rd     = instr_i[11:7];

  assign rf_raddr_a_o = rs1;
  assign rf_raddr_b_o = rs2;
  assign rf_waddr_o   = rd;

  ////////////////////
  // Opcode decode
  ////////////////////

  always_comb begin
    alu_operator_o = ADD;
    op_a_sel_o     = OP_A_REG;
    op_b_sel_o     = OP_B_IMM;
    imm_b_sel_o    = IMM_B_I;
    lsu_type_o     = LSU_WORD;
    lsu_sign_ext_o = 1'b0;
    rf_we_raw      = 1'b0;
    lsu_raw        = 1'b0;
    lsu_we_raw     = 1'b0;
    branch_raw     = 1'b0;
    jump_raw       = 1'b0;
    rs1_used       = 1'b0;
    rs2_used       = 1'b0;
    rd_used        = 1'b0;
    illegal_enc    = 1'b0;

    case (opcode)
      OP, OP_IMM: begin
        rf_we_raw  = 1'b1;
        rs1_used   = 1'b1;
        rd_used    = 1'b1;
        rs2_used   = (opcode == OP);
        op_b_sel_o = (opcode == OP) ? OP_B_REG : OP_B_IMM;
        case (funct3)
          3'b000: begin
            // SUB only exists in the register form
            alu_operator_o = (opcode == OP && funct7 == 7'h20) ? SUB : ADD;
            illegal_enc    = (opcode == OP) && !(funct7 inside {7'h00, 7'h20});
          end
          3'b001: begin
            alu_operator_o = SLL;
            illegal_enc    = (funct7 != 7'h00);
          end
          3'b101: begin
            alu_operator_o = (funct7 == 7'h20) ? SRA : SRL;
            illegal_enc    = !(funct7 inside {7'h00, 7'h20});
          end
          3'b010: alu_operator_o = SLT;
          3'b011: alu_operator_o = SLTU;
          3'b100: alu_operator_o = XOR;
          3'b110: alu_operator_o = OR;
          default: alu_operator_o = AND;
        endcase
        // Remaining register ops need funct7 zero
        if (opcode == OP && !(funct3 inside {3'b000, 3'b101}) && funct7 != 7'h00) begin
          illegal_enc = 1'b1;
        end
      end
      LUI, AUIPC: begin
        op_a_sel_o  = (opcode == LUI) ? OP_A_ZERO : OP_A_PC;
        imm_b_sel_o = IMM_B_U;
        rf_we_raw   = 1'b1;
        rd_used     = 1'b1;
      end
      LOAD: begin
        lsu_raw        = 1'b1;
        rf_we_raw      = 1'b1;
        rs1_used       = 1'b1;
        rd_used        = 1'b1;
        lsu_sign_ext_o = ~funct3[2];
        case (funct3)
          3'b000, 3'b100: lsu_type_o = LSU_BYTE;
          3'b001, 3'b101: lsu_type_o = LSU_HALF;
          3'b010:         lsu_type_o = LSU_WORD;
          default:        illegal_enc = 1'b1;
        endcase
      end
      STORE: begin
        lsu_raw     = 1'b1;
        lsu_we_raw  = 1'b1;
        rs1_used    = 1'b1;
        rs2_used    = 1'b1;
        imm_b_sel_o = IMM_B_S;
        case (funct3)
          3'b000:  lsu_type_o = LSU_BYTE;
          3'b001:  lsu_type_o = LSU_HALF;
          3'b010:  lsu_type_o = LSU_WORD;
          default: illegal_enc = 1'b1;
        endcase
      end
      BRANCH: begin
        // Comparison on the ALU, decision comes back externally
        branch_raw = 1'b1;
        op_b_sel_o = OP_B_REG;
        rs1_used   = 1'b1;
        rs2_used   = 1'b1;
        case (funct3)
          3'b000, 3'b001: alu_operator_o = SUB;
          3'b100, 3'b101: alu_operator_o = SLT;
          3'b110, 3'b111: alu_operator_o = SLTU;
          default:        illegal_enc = 1'b1;
        endcase
      end
      JAL: begin
        // Link value is PC + 4
        jump_raw    = 1'b1;
        rf_we_raw   = 1'b1;
        rd_used     = 1'b1;
        op_a_sel_o  = OP_A_PC;
        imm_b_sel_o = IMM_B_INCR_PC;
      end
      default: illegal_enc = 1'b1;
    endcase
  end

  // RV32E limit on any register field in use
  assign illegal_reg = (rs1_used & (rs1 >= NumRegs)) |
                       (rs2_used & (rs2 >= NumRegs)) |
                       (rd_used  & (rd  >= NumRegs));

  assign illegal_o = illegal_enc | illegal_reg;

  assign rf_we_dec_o  = rf_we_raw  & ~illegal_o;
  assign lsu_dec_o    = lsu_raw    & ~illegal_o;
  assign lsu_we_o     = lsu_we_raw & ~illegal_o;
  assign branch_dec_o = branch_raw & ~illegal_o;
  assign jump_dec_o   = jump_raw   & ~illegal_o;

endmodule

// File: design/id_operand_mux.sv
////////////////////
// ALU operand muxing
// Immediate generation and operand A/B selection
////////////////////

`timescale 1ns/1ns

module id_operand_mux import id_pkg::*; (
  input  logic [XLEN-1:0] instr_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic [XLEN-1:0] rf_rdata_a_i,
  input  logic [XLEN-1:0] rf_rdata_b_i,
  input  op_a_sel_e       op_a_sel_i,
  input  op_b_sel_e       op_b_sel_i,
  input  imm_b_sel_e      imm_b_sel_i,
  output logic [XLEN-1:0] alu_operand_a_o,
  output logic [XLEN-1:0] alu_operand_b_o
);

  logic [XLEN-1:0] imm_i_type;
  logic [XLEN-1:0] imm_s_type;
  logic [XLEN-1:0] imm_u_type;
  logic [XLEN-1:0] imm_b;

  ////////////////////
  // Immediates
  ////////////////////

  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  // Upper immediate, low 12 bits zero
  assign imm_u_type = {instr_i[31:12], 12'b0};

  always_comb begin
    case (imm_b_sel_i)
      IMM_B_I:       imm_b = imm_i_type;
      IMM_B_S:       imm_b = imm_s_type;
      IMM_B_U:       imm_b = imm_u_type;
      IMM_B_INCR_PC: imm_b = 32'h4;
      default:       imm_b = 32'h4;
    endcase
  end

  ////////////////////
  // Operand selects
  ////////////////////

  // LUI takes zero, AUIPC and JAL take the PC
  always_comb begin
    case (op_a_sel_i)
      OP_A_REG:  alu_operand_a_o = rf_rdata_a_i;
      OP_A_PC:   alu_operand_a_o = pc_i;
      OP_A_ZERO: alu_operand_a_o = '0;
      default:   alu_operand_a_o = rf_rdata_a_i;
    endcase
  end

  assign alu_operand_b_o = (op_b_sel_i == OP_B_IMM) ? imm_b : rf_rdata_b_i;

endmodule

// File: design/id_pkg.sv
////////////////////
// Decode stage definitions
// Widths, opcodes, ALU operators and mux selects shared by the ID blocks
////////////////////

package id_pkg;

  // Datapath and register file sizes
  localparam int unsigned XLEN             = 32;
  localparam int unsigned REG_ADDR_W       = 5;
  localparam int unsigned NUM_REGS_DEFAULT = 32;

  ////////////////////
  // Major opcodes
  ////////////////////

  typedef enum logic [6:0] {
    OP     = 7'h33,
    OP_IMM = 7'h13,
    LUI    = 7'h37,
    AUIPC  = 7'h17,
    LOAD   = 7'h03,
    STORE  = 7'h23,
    BRANCH = 7'h63,
    JAL    = 7'h6f
  } opcode_e;

  // ALU operator handed to the execute side
  typedef enum logic [3:0] {
    ADD,
    SUB,
    XOR,
    OR,
    AND,
    SLL,
    SRL,
    SRA,
    SLT,
    SLTU
  } alu_op_e;

  ////////////////////
  // Operand selects
  ////////////////////

  typedef enum logic [1:0] {
    OP_A_REG,
    OP_A_PC,
    OP_A_ZERO
  } op_a_sel_e;

  typedef enum logic {
    OP_B_REG,
    OP_B_IMM
  } op_b_sel_e;

  // IMM_B_INCR_PC is the constant 4 for link values
  typedef enum logic [2:0] {
    IMM_B_I,
    IMM_B_S,
    IMM_B_U,
    IMM_B_INCR_PC
  } imm_b_sel_e;

  // Access size, same coding as the data interface
  typedef enum logic [1:0] {
    LSU_WORD = 2'b00,
    LSU_HALF = 2'b01,
    LSU_BYTE = 2'b10
  } lsu_type_e;

  // ID FSM states
  typedef enum logic {
    FIRST_CYCLE,
    MULTI_CYCLE
  } id_fsm_e;

endpackage

// File: design/id_stage_top.sv
////////////////////
// RV32I decode stage
// Connects decoder, operand mux and controller
////////////////////

`timescale 1ns/1ns

module id_stage_top import id_pkg::*; #(
  parameter int unsigned NumRegs = NUM_REGS_DEFAULT
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Fetch side
  input  logic                  instr_valid_i,
  input  logic [XLEN-1:0]       instr_i,
  input  logic [XLEN-1:0]       pc_i,
  output logic                  id_ready_o,
  output logic                  instr_done_o,
  output logic                  illegal_insn_o,
  // Register file
  output logic [REG_ADDR_W-1:0] rf_raddr_a_o,
  output logic [REG_ADDR_W-1:0] rf_raddr_b_o,
  input  logic [XLEN-1:0]       rf_rdata_a_i,
  input  logic [XLEN-1:0]       rf_rdata_b_i,
  output logic [REG_ADDR_W-1:0] rf_waddr_o,
  output logic                  rf_we_o,
  // ALU
  output alu_op_e               alu_operator_o,
  output logic [XLEN-1:0]       alu_operand_a_o,
  output logic [XLEN-1:0]       alu_operand_b_o,
  input  logic                  branch_decision_i,
  // LSU
  output logic                  lsu_req_o,
  output logic                  lsu_we_o,
  output lsu_type_e             lsu_type_o,
  output logic                  lsu_sign_ext_o,
  output logic [XLEN-1:0]       lsu_wdata_o,
  input  logic                  lsu_resp_valid_i,
  output logic                  pc_set_o
);

  op_a_sel_e  op_a_sel;
  op_b_sel_e  op_b_sel;
  imm_b_sel_e imm_b_sel;
  logic       rf_we_dec, lsu_dec, lsu_we, branch_dec, jump_dec, illegal_dec;

  id_decoder #(
    .NumRegs(NumRegs)
  ) i_id_decoder (
    .instr_i       (instr_i),
    .alu_operator_o(alu_operator_o),
    .op_a_sel_o    (op_a_sel),
    .op_b_sel_o    (op_b_sel),
    .imm_b_sel_o   (imm_b_sel),
    .rf_raddr_a_o  (rf_raddr_a_o),
    .rf_raddr_b_o  (rf_raddr_b_o),
    .rf_waddr_o    (rf_waddr_o),
    .rf_we_dec_o   (rf_we_dec),
    .lsu_dec_o     (lsu_dec),
    .lsu_we_o      (lsu_we),
    .lsu_type_o    (lsu_type_o),
    .lsu_sign_ext_o(lsu_sign_ext_o),
    .branch_dec_o  (branch_dec),
    .jump_dec_o    (jump_dec),
    .illegal_o     (illegal_dec)
  );

  id_operand_mux i_id_operand_mux (
    .instr_i        (instr_i),
    .pc_i           (pc_i),
    .rf_rdata_a_i   (rf_rdata_a_i),
    .rf_rdata_b_i   (rf_rdata_b_i),
    .op_a_sel_i     (op_a_sel),
    .op_b_sel_i     (op_b_sel),
    .imm_b_sel_i    (imm_b_sel),
    .alu_operand_a_o(alu_operand_a_o),
    .alu_operand_b_o(alu_operand_b_o)
  );

  id_controller i_id_controller (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .instr_valid_i    (instr_valid_i),
    .illegal_i        (illegal_dec),
    .branch_dec_i     (branch_dec),
    .jump_dec_i       (jump_dec),
    .lsu_dec_i        (lsu_dec),
    .rf_we_dec_i      (rf_we_dec),
    .lsu_we_i         (lsu_we),
    .branch_decision_i(branch_decision_i),
    .lsu_resp_valid_i (lsu_resp_valid_i),
    .lsu_req_o        (lsu_req_o),
    .rf_we_o          (rf_we_o),
    .pc_set_o         (pc_set_o),
    .instr_done_o     (instr_done_o),
    .illegal_insn_o   (illegal_insn_o)
  );

  // Store data straight from register port B
  assign lsu_wdata_o = rf_rdata_b_i;
  assign lsu_we_o    = lsu_we;
  assign id_ready_o  = instr_done_o;

endmodule

// File: testbench/id_controller_assertions.sv
////////////////////
// ID controller checks
// Handshake and PC set rules, bound into the controller
////////////////////

`timescale 1ns/1ns

module id_controller_assertions (
  input logic clk_i,
  input logic rst_ni,
  input logic instr_valid_i,
  input logic instr_done_i,
  input logic lsu_req_i,
  input logic pc_set_i,
  input logic rf_we_i
);

  int unsigned failure_count = 0;

  // Request cycle never retires the instruction
  lsu_req_not_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lsu_req_i |-> !instr_done_i)
    else begin
      $error("lsu_req_o and instr_done_o high in the same cycle");
      failure_count++;
    end

  pc_set_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pc_set_i |=> !pc_set_i)
    else begin
      $error("pc_set_o high on two consecutive cycles");
      failure_count++;
    end

  done_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_done_i |-> instr_valid_i)
    else begin
      $error("instr_done_o without instr_valid_i");
      failure_count++;
    end

  // Writes only on retirement
  we_needs_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rf_we_i |-> instr_done_i)
    else begin
      $error("rf_we_o without instr_done_o");
      failure_count++;
    end

endmodule

bind id_controller id_controller_assertions i_id_controller_assertions (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .instr_valid_i(instr_valid_i),
  .instr_done_i (instr_done_o),
  .lsu_req_i    (lsu_req_o),
  .pc_set_i     (pc_set_o),
  .rf_we_i      (rf_we_o)
);

// File: testbench/id_stage_tb.sv
////////////////////
// Decode stage testbench
// Runs a table of instructions through the ID stage and checks every cycle
////////////////////

`timescale 1ns/1ns

module id_stage_tb import id_pkg::*; ();

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 4;
  localparam int NUM_ROWS     = 21;
  localparam int TIMEOUT      = (NUM_ROWS * 20 + RESET_CYCLES) * CLK_PERIOD;

  // Expected flag bits of a row
  localparam logic [5:0] F_WE   = 6'b100000;
  localparam logic [5:0] F_LSU  = 6'b010000;
  localparam logic [5:0] F_ST   = 6'b001000;
  localparam logic [5:0] F_SEXT = 6'b000100;
  localparam logic [5:0] F_JMP  = 6'b000010;
  localparam logic [5:0] F_ILL  = 6'b000001;
  localparam logic [5:0] F_LD   = F_WE | F_LSU;
  localparam logic [5:0] F_LDS  = F_LD | F_SEXT;
  localparam logic [5:0] F_SW   = F_LSU | F_ST;
  localparam logic [5:0] F_LINK = F_WE | F_JMP;

  typedef struct packed {
    logic [31:0] instr;
    logic        taken;
    int          delay;
    alu_op_e     op;
    op_a_sel_e   a_sel;
    op_b_sel_e   b_sel;
    imm_b_sel_e  imm_sel;
    lsu_type_e   lsu_type;
    logic [5:0]  flags;
  } row_t;

  logic clk_i, rst_ni, instr_valid_i, branch_decision_i, lsu_resp_valid_i;
  logic [XLEN-1:0] instr_i, pc_i, rf_rdata_a_i, rf_rdata_b_i;
  logic id_ready_o, instr_done_o, illegal_insn_o, rf_we_o, pc_set_o;
  logic lsu_req_o, lsu_we_o, lsu_sign_ext_o;
  logic [REG_ADDR_W-1:0] rf_raddr_a_o, rf_raddr_b_o, rf_waddr_o;
  logic [XLEN-1:0] alu_operand_a_o, alu_operand_b_o, lsu_wdata_o;
  alu_op_e   alu_operator_o;
  lsu_type_e lsu_type_o;

  row_t        rows[NUM_ROWS];
  string       row_name[NUM_ROWS];
  int          row_count;
  string       current_test;

  id_stage_top #(
    .NumRegs(32)
  ) i_id_stage_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic stop_with_failure(string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
    if (expected !== actual) begin
      stop_with_failure($sformatf("Fail %s %s: expected %h, actual %h",
                                  current_test, what, expected, actual));
    end
  endtask

  task automatic add_row(string name, logic [31:0] instr, int taken, int delay, alu_op_e op,
                         op_a_sel_e a_sel, op_b_sel_e b_sel, imm_b_sel_e imm_sel,
                         lsu_type_e lsu_type, logic [5:0] flags);
    rows[row_count]     = '{instr, (taken != 0), delay, op, a_sel, b_sel, imm_sel, lsu_type, flags};
    row_name[row_count] = name;
    row_count++;
  endtask

  function automatic logic [31:0] expected_operand_a(row_t r, logic [31:0] pc, logic [31:0] rd_a);
    case (r.a_sel)
      OP_A_PC:   return pc;
      OP_A_ZERO: return 32'h0;
      default:   return rd_a;
    endcase
  endfunction

  // Immediate layouts from the RV32I encoding
  function automatic logic [31:0] expected_operand_b(row_t r, logic [31:0] rd_b);
    logic [31:0] ins;
    ins = r.instr;
    if (r.b_sel == OP_B_REG) return rd_b;
    case (r.imm_sel)
      IMM_B_I: return {{20{ins[31]}}, ins[31:20]};
      IMM_B_S: return {{20{ins[31]}}, ins[31:25], ins[11:7]};
      IMM_B_U: return {ins[31:12], 12'h000};
      default: return 32'd4;
    endcase
  endfunction

  ////////////////////
  // Stimulus table
  ////////////////////

  task automatic build_table();
    row_count = 0;
    add_row("add", 32'h00c58533, 0, 0, ADD, OP_A_REG, OP_B_REG, IMM_B_I, LSU_WORD, F_WE);
    add_row("sub", 32'h40c58533, 0, 0, SUB, OP_A_REG, OP_B_REG, IMM_B_I, LSU_WORD, F_WE);
    add_row("xor", 32'h00c5c533, 0, 0, XOR, OP_A_REG, OP_B_REG, IMM_B_I, LSU_WORD, F_WE);
    add_row("sra", 32'h40c5d533, 0, 0, SRA, OP_A_REG, OP_B_REG, IMM_B_I, LSU_WORD, F_WE);
    add_row("sltu", 32'h00c5b533, 0, 0, SLTU, OP_A_REG, OP_B_REG, IMM_B_I, LSU_WORD, F_WE);
    add_row("addi", 32'hffd30293, 0, 0, ADD, OP_A_REG, OP_B_IMM, IMM_B_I, LSU_WORD, F_WE);
    add_row("andi", 32'h0f047393, 0, 0, AND, OP_A_REG, OP_B_IMM, IMM_B_I, LSU_WORD, F_WE);
    add_row("srai", 32'h4044d493, 0, 0, SRA, OP_A_REG, OP_B_IMM, IMM_B_I, LSU_WORD, F_WE);
    add_row("lui", 32'habcde0b7, 0, 0, ADD, OP_A_ZERO, OP_B_IMM, IMM_B_U, LSU_WORD, F_WE);
    add_row("auipc", 32'h80001117, 0, 0, ADD, OP_A_PC, OP_B_IMM, IMM_B_U, LSU_WORD, F_WE);
    add_row("lw", 32'hff822183, 0, 3, ADD, OP_A_REG, OP_B_IMM, IMM_B_I, LSU_WORD, F_LDS);
    add_row("lbu", 32'h00524183, 0, 1, ADD, OP_A_REG, OP_B_IMM, IMM_B_I, LSU_BYTE, F_LD);
    add_row("lh", 32'h00221183, 0, 5, ADD, OP_A_REG, OP_B_IMM, IMM_B_I, LSU_HALF, F_LDS);
    add_row("sw", 32'h00532623, 0, 2, ADD, OP_A_REG, OP_B_IMM, IMM_B_S, LSU_WORD, F_SW);
    add_row("sb", 32'hfe530fa3, 0, 4, ADD, OP_A_REG, OP_B_IMM, IMM_B_S, LSU_BYTE, F_SW);
    add_row("beq taken", 32'h00208463, 1, 0, SUB, OP_A_REG, OP_B_REG, IMM_B_I, LSU_WORD, 6'b0);
    add_row("bltu not taken", 32'h0020e463, 0, 0, SLTU, OP_A_REG, OP_B_REG, IMM_B_I, LSU_WORD,
            6'b0);
    add_row("blt taken", 32'h0020c463, 1, 0, SLT, OP_A_REG, OP_B_REG, IMM_B_I, LSU_WORD, 6'b0);
    add_row("jal", 32'h010000ef, 0, 0, ADD, OP_A_PC, OP_B_IMM, IMM_B_INCR_PC, LSU_WORD, F_LINK);
    add_row("bad opcode", 32'h00000000, 0, 0, ADD, OP_A_REG, OP_B_REG, IMM_B_I, LSU_WORD, F_ILL);
    add_row("bad funct7", 32'h02c58533, 0, 0, ADD, OP_A_REG, OP_B_REG, IMM_B_I, LSU_WORD, F_ILL);
  endtask

  ////////////////////
  // Row execution
  ////////////////////

  task automatic run_row(int idx);
    row_t        r;
    logic [31:0] pc_val, rd_a, rd_b, exp_a, exp_b;
    logic        we, lsu, st, ill, jmp, last, done_seen;
    int          num_cycles, cyc;
    r            = rows[idx];
    current_test = row_name[idx];
    {we, lsu, st, ill, jmp} = {|(r.flags & F_WE), |(r.flags & F_LSU), |(r.flags & F_ST),
                               |(r.flags & F_ILL), |(r.flags & F_JMP)};
    // Idle cycle, nothing may fire without a valid instruction
    @(negedge clk_i);
    check_value("idle instr_done_o", 0, instr_done_o);
    check_value("idle pc_set_o", 0, pc_set_o);
    check_value("idle lsu_req_o", 0, lsu_req_o);
    check_value("idle rf_we_o", 0, rf_we_o);
    pc_val = $urandom;
    rd_a   = $urandom;
    rd_b   = $urandom;
    exp_a  = expected_operand_a(r, pc_val, rd_a);
    exp_b  = expected_operand_b(r, rd_b);
    if (lsu) num_cycles = r.delay + 1;
    else if (jmp || r.taken) num_cycles = 2;
    else num_cycles = 1;
    @(posedge clk_i);
    instr_valid_i     <= 1'b1;
    instr_i           <= r.instr;
    pc_i              <= pc_val;
    rf_rdata_a_i      <= rd_a;
    rf_rdata_b_i      <= rd_b;
    branch_decision_i <= r.taken;
    lsu_resp_valid_i  <= 1'b0;
    cyc       = 0;
    done_seen = 1'b0;
    while (!done_seen) begin
      @(negedge clk_i);
      cyc++;
      last      = (cyc == num_cycles);
      done_seen = instr_done_o;
      if (done_seen !== last) begin
        stop_with_failure($sformatf(
          "%s: instr_done_o is %b in cycle %0d, retire expected in cycle %0d",
          current_test, instr_done_o, cyc, num_cycles));
      end
      check_value("id_ready_o", last, id_ready_o);
      check_value("illegal_insn_o", ill, illegal_insn_o);
      check_value("rf_we_o", we && last, rf_we_o);
      check_value("lsu_req_o", lsu && cyc == 1, lsu_req_o);
      check_value("pc_set_o", jmp ? (cyc == 1) : (r.taken && cyc == 2), pc_set_o);
      check_value("rf_raddr_a_o", r.instr[19:15], rf_raddr_a_o);
      check_value("rf_raddr_b_o", r.instr[24:20], rf_raddr_b_o);
      if (!ill) begin
        check_value("alu_operator_o", r.op, alu_operator_o);
        check_value("alu_operand_a_o", exp_a, alu_operand_a_o);
        check_value("alu_operand_b_o", exp_b, alu_operand_b_o);
        if (we) check_value("rf_waddr_o", r.instr[11:7], rf_waddr_o);
      end
      if (lsu) begin
        check_value("lsu_we_o", st, lsu_we_o);
        check_value("lsu_type_o", r.lsu_type, lsu_type_o);
        check_value("lsu_sign_ext_o", |(r.flags & F_SEXT), lsu_sign_ext_o);
        if (st) check_value("lsu_wdata_o", rd_b, lsu_wdata_o);
      end
      @(posedge clk_i);
      if (done_seen) begin
        instr_valid_i    <= 1'b0;
        lsu_resp_valid_i <= 1'b0;
      end else begin
        // One-cycle response, arriving r.delay cycles after the request
        lsu_resp_valid_i <= lsu && (cyc == r.delay);
      end
    end
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    rst_ni            <= 1'b0;
    instr_valid_i     <= 1'b0;
    instr_i           <= '0;
    pc_i              <= '0;
    rf_rdata_a_i      <= '0;
    rf_rdata_b_i      <= '0;
    branch_decision_i <= 1'b0;
    lsu_resp_valid_i  <= 1'b0;
    void'($urandom(32'h1a2c));
    build_table();
    if (row_count != NUM_ROWS) begin
      stop_with_failure($sformatf("Stimulus table has %0d rows instead of %0d",
                                  row_count, NUM_ROWS));
    end
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(i);
    end
    @(negedge clk_i);
    if (i_id_stage_top.i_id_controller.i_id_controller_assertions.failure_count == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      $display("Controller assertions failed during the run");
      $display("** FAIL **");
      $fatal(1);
    end
  end

  // Watchdog
  initial begin
    #(TIMEOUT);
    $display("Timeout: the run did not complete within %0d ns", TIMEOUT);
    $display("** FAIL **");
    $fatal(1);
  end

endmodule
